// File: switch_pkg.sv
`default_nettype none

package switch_pkg;

    typedef logic [47:0] mac_addr_t;

    localparam mac_addr_t BROADCAST_MAC = 48'hFFFF_FFFF_FFFF;

    // Header descriptor carried from ingress to the decision stage
    typedef struct packed {
        mac_addr_t dst_mac;
        mac_addr_t src_mac;
    } mac_pair_t;

    localparam int NUM_ENTRIES = 8;
    localparam int MAX_HIT     = 8;
    localparam int HIT_W       = $clog2(MAX_HIT);

    typedef logic [$clog2(NUM_ENTRIES)-1:0] entry_idx_t;
    typedef logic [HIT_W-1:0]               hit_cnt_t;
    typedef hit_cnt_t [NUM_ENTRIES-1:0]     hit_vec_t;

    localparam hit_cnt_t HIT_SAT = hit_cnt_t'(MAX_HIT - 1); // Counter ceiling

    typedef enum logic [1:0] {
        FWD_UNICAST,
        FWD_FLOOD,
        FWD_FILTER,
        FWD_BROADCAST
    } fwd_kind_t;

    // Lowest free slot first, otherwise the least used entry
    function automatic entry_idx_t free_index(
        input logic [NUM_ENTRIES-1:0] usage,
        input hit_vec_t               hits
    );
        entry_idx_t idx;
        hit_cnt_t   lowest;
        logic       found;

        idx    = '0;
        lowest = hits[0];
        found  = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!usage[i] && !found) begin
                idx   = entry_idx_t'(i);
                found = 1'b1;
            end
        end
        if (!found) begin
            for (int i = 1; i < NUM_ENTRIES; i++) begin
                if (hits[i] < lowest) begin // Strict compare keeps lowest index on ties
                    lowest = hits[i];
                    idx    = entry_idx_t'(i);
                end
            end
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

// File: desc_fifo.sv
`default_nettype none

module desc_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push_i,
    input  switch_pkg::mac_pair_t push_desc_i,
    input  logic                  pop_i,
    output switch_pkg::mac_pair_t head_desc_o,
    output logic                  empty_o,
    output logic                  full_o
);
    import switch_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    mac_pair_t        mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = push_i && !full_o; // Writes while full are dropped
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_desc_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // Idle or push with pop
            endcase
        end
    end

    assign head_desc_o = mem[rd_ptr_q];
    assign empty_o     = (count_q == '0);
    assign full_o      = (count_q == CNT_W'(FIFO_DEPTH));

endmodule

`default_nettype wire

// File: rr_arbiter.sv
`default_nettype none

module rr_arbiter #(
    parameter int NUM_PORTS = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [NUM_PORTS-1:0]         req_i,
    output logic                         grant_valid_o,
    output logic [$clog2(NUM_PORTS)-1:0] grant_port_o
);

    localparam int PORT_W = $clog2(NUM_PORTS);

    logic [PORT_W-1:0] last_q;
    logic              found;
    logic [PORT_W-1:0] pick;

    // Search starts one past the previous winner
    always_comb begin
        int idx;

        found = 1'b0;
        pick  = last_q;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            idx = (int'(last_q) + k) % NUM_PORTS;
            if (!found && req_i[idx]) begin
                found = 1'b1;
                pick  = PORT_W'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q <= PORT_W'(NUM_PORTS - 1); // Port 0 goes first
        end else if (found) begin
            last_q <= pick;
        end
    end

    assign grant_valid_o = found;
    assign grant_port_o  = pick;

endmodule

`default_nettype wire

// File: address_table.sv
`default_nettype none

module address_table #(
    parameter int NUM_PORTS = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         learn_req_i,
    input  switch_pkg::mac_addr_t        learn_address_i,
    input  logic [$clog2(NUM_PORTS)-1:0] learn_port_i,
    input  logic                         read_req_i,
    input  switch_pkg::mac_addr_t        read_address_i,
    output logic [$clog2(NUM_PORTS)-1:0] read_port_o,
    output logic                         read_port_valid_o
);
    import switch_pkg::*;

    localparam int PORT_W = $clog2(NUM_PORTS);

    mac_addr_t              table_addr [NUM_ENTRIES];
    logic [PORT_W-1:0]      table_port [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] table_used;
    hit_vec_t               table_hits;

    entry_idx_t             next_index;
    logic                   learn_exists;
    logic                   learn_write;
    logic [NUM_ENTRIES-1:0] read_match;
    logic                   read_hit;
    entry_idx_t             read_index;

    always_comb begin
        next_index   = free_index(table_used, table_hits);
        learn_exists = 1'b0;
        read_hit     = 1'b0;
        read_index   = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (table_used[i] && table_addr[i] == learn_address_i
                    && table_port[i] == learn_port_i) begin
                learn_exists = 1'b1;
            end
            // Stale entries never match
            read_match[i] = table_used[i] && (table_addr[i] == read_address_i);
            if (read_match[i]) begin
                read_hit   = 1'b1;
                read_index = entry_idx_t'(i);
            end
        end
    end

    assign learn_write = learn_req_i && !learn_exists;

    always_ff @(posedge clk) begin
        if (learn_write) begin
            table_addr[next_index] <= learn_address_i;
            table_port[next_index] <= learn_port_i;
        end
        if (read_req_i && read_hit) begin
            read_port_o <= table_port[read_index];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            table_used        <= '0;
            table_hits        <= '0;
            read_port_valid_o <= 1'b0;
        end else begin
            read_port_valid_o <= read_req_i && read_hit;
            if (learn_req_i) begin
                for (int i = 0; i < NUM_ENTRIES; i++) begin
                    if (table_used[i] && table_addr[i] == learn_address_i
                            && table_port[i] != learn_port_i) begin
                        table_used[i] <= 1'b0; // Station moved to another port
                    end
                end
                if (!learn_exists) begin
                    table_used[next_index] <= 1'b1;
                    table_hits[next_index] <= hit_cnt_t'(1);
                end
            end
            if (read_req_i) begin
                for (int i = 0; i < NUM_ENTRIES; i++) begin
                    // Slot being written this edge keeps its fresh count
                    if (!(learn_write && entry_idx_t'(i) == next_index)) begin
                        if (read_match[i]) begin
                            if (table_hits[i] != HIT_SAT) table_hits[i] <= table_hits[i] + 1'b1;
                        end else if (table_hits[i] != '0) begin
                            table_hits[i] <= table_hits[i] - 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: forward_decision.sv
`default_nettype none

module forward_decision #(
    parameter int NUM_PORTS = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req_valid_i,
    input  switch_pkg::mac_pair_t        req_desc_i,
    input  logic [$clog2(NUM_PORTS)-1:0] req_src_port_i,
    input  logic                         hit_i,
    input  logic [$clog2(NUM_PORTS)-1:0] hit_port_i,
    output logic                         fwd_valid_o,
    output switch_pkg::mac_pair_t        fwd_desc_o,
    output logic [$clog2(NUM_PORTS)-1:0] fwd_src_port_o,
    output logic [NUM_PORTS-1:0]         fwd_mask_o,
    output switch_pkg::fwd_kind_t        fwd_kind_o
);
    import switch_pkg::*;

    logic [NUM_PORTS-1:0] src_onehot;
    logic [NUM_PORTS-1:0] hit_onehot;
    logic [NUM_PORTS-1:0] next_mask;
    fwd_kind_t            next_kind;

    always_comb begin
        src_onehot                 = '0;
        src_onehot[req_src_port_i] = 1'b1;
        hit_onehot                 = '0;
        hit_onehot[hit_port_i]     = 1'b1;

        // First matching rule wins
        if (req_desc_i.dst_mac == BROADCAST_MAC) begin
            next_kind = FWD_BROADCAST;
            next_mask = ~src_onehot;
        end else if (hit_i && hit_port_i != req_src_port_i) begin
            next_kind = FWD_UNICAST;
            next_mask = hit_onehot;
        end else if (hit_i) begin
            next_kind = FWD_FILTER; // Destination sits behind the ingress port
            next_mask = '0;
        end else begin
            next_kind = FWD_FLOOD;
            next_mask = ~src_onehot;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fwd_valid_o <= 1'b0;
        end else begin
            fwd_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            fwd_desc_o     <= req_desc_i;
            fwd_src_port_o <= req_src_port_i;
            fwd_mask_o     <= next_mask;
            fwd_kind_o     <= next_kind;
        end
    end

endmodule

`default_nettype wire

// File: forwarding_engine.sv
`default_nettype none

module forwarding_engine #(
    parameter int NUM_PORTS  = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [NUM_PORTS-1:0]         in_valid_i,
    input  switch_pkg::mac_pair_t        in_desc_i [NUM_PORTS],
    output logic [NUM_PORTS-1:0]         in_full_o,
    output logic                         fwd_valid_o,
    output switch_pkg::mac_pair_t        fwd_desc_o,
    output logic [$clog2(NUM_PORTS)-1:0] fwd_src_port_o,
    output logic [NUM_PORTS-1:0]         fwd_mask_o,
    output switch_pkg::fwd_kind_t        fwd_kind_o
);
    import switch_pkg::*;

    localparam int PORT_W = $clog2(NUM_PORTS);

    typedef struct packed {
        mac_pair_t         desc;
        logic [PORT_W-1:0] port;
    } stage_t;

    mac_pair_t            head_desc [NUM_PORTS];
    logic [NUM_PORTS-1:0] fifo_empty;
    logic [NUM_PORTS-1:0] fifo_pop;
    logic                 grant_valid;
    logic [PORT_W-1:0]    grant_port;
    logic                 stage_valid_q;
    stage_t               stage_q;
    logic                 align_valid_q;
    stage_t               align_q;
    logic                 hit;
    logic [PORT_W-1:0]    hit_port;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        assign fifo_pop[p] = grant_valid && (grant_port == PORT_W'(p));

        desc_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
            .clk         (clk),
            .rst_n       (rst_n),
            .push_i      (in_valid_i[p]),
            .push_desc_i (in_desc_i[p]),
            .pop_i       (fifo_pop[p]),
            .head_desc_o (head_desc[p]),
            .empty_o     (fifo_empty[p]),
            .full_o      (in_full_o[p])
        );
    end

    rr_arbiter #(.NUM_PORTS(NUM_PORTS)) u_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_i         (~fifo_empty),
        .grant_valid_o (grant_valid),
        .grant_port_o  (grant_port)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid_q <= 1'b0;
            align_valid_q <= 1'b0;
        end else begin
            stage_valid_q <= grant_valid;
            align_valid_q <= stage_valid_q; // Lines up with the table result
        end
    end

    always_ff @(posedge clk) begin
        if (grant_valid) stage_q <= '{desc: head_desc[grant_port], port: grant_port};
        if (stage_valid_q) align_q <= stage_q;
    end

    // Learn source and look up destination on the same edge
    address_table #(.NUM_PORTS(NUM_PORTS)) u_table (
        .clk               (clk),
        .rst_n             (rst_n),
        .learn_req_i       (stage_valid_q),
        .learn_address_i   (stage_q.desc.src_mac),
        .learn_port_i      (stage_q.port),
        .read_req_i        (stage_valid_q),
        .read_address_i    (stage_q.desc.dst_mac),
        .read_port_o       (hit_port),
        .read_port_valid_o (hit)
    );

    forward_decision #(.NUM_PORTS(NUM_PORTS)) u_decide (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid_i    (align_valid_q),
        .req_desc_i     (align_q.desc),
        .req_src_port_i (align_q.port),
        .hit_i          (hit),
        .hit_port_i     (hit_port),
        .fwd_valid_o    (fwd_valid_o),
        .fwd_desc_o     (fwd_desc_o),
        .fwd_src_port_o (fwd_src_port_o),
        .fwd_mask_o     (fwd_mask_o),
        .fwd_kind_o     (fwd_kind_o)
    );

endmodule

`default_nettype wire

// File: tb_forwarding_engine.sv
`default_nettype none

module tb_forwarding_engine;
    timeunit 1ns;
    timeprecision 1ps;

    import switch_pkg::*;

    localparam int NUM_PORTS    = 4;
    localparam int FIFO_DEPTH   = 4;
    localparam int PORT_W       = $clog2(NUM_PORTS);
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int STIM_CYCLES  = 3000;
    localparam int DRAIN_CYCLES = NUM_PORTS * FIFO_DEPTH + 10;
    localparam int LAT_LIMIT    = 16;
    localparam int POOL_SIZE    = 12; // Unicast stations, more than the table holds
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + LAT_LIMIT + STIM_CYCLES + DRAIN_CYCLES + 8;

    logic                 clk = 1'b0;
    logic                 rst_n = 1'b0;
    logic [NUM_PORTS-1:0] in_valid = '0;
    mac_pair_t            in_desc [NUM_PORTS] = '{default: '0};
    logic [NUM_PORTS-1:0] in_full;
    logic                 fwd_valid;
    mac_pair_t            fwd_desc;
    logic [PORT_W-1:0]    fwd_src_port;
    logic [NUM_PORTS-1:0] fwd_mask;
    fwd_kind_t            fwd_kind;

    // Reference state
    mac_pair_t model_q [NUM_PORTS][$];
    mac_addr_t ref_addr [NUM_ENTRIES];
    int        ref_port [NUM_ENTRIES];
    bit        ref_used [NUM_ENTRIES];
    int        ref_hits [NUM_ENTRIES];
    int        kind_seen [4];
    int        accepted;
    int        dropped;
    int        forwarded;
    int        evictions;
    int        moves;

    always #(CLK_PERIOD / 2) clk = ~clk;

    forwarding_engine #(.NUM_PORTS(NUM_PORTS), .FIFO_DEPTH(FIFO_DEPTH)) UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid_i     (in_valid),
        .in_desc_i      (in_desc),
        .in_full_o      (in_full),
        .fwd_valid_o    (fwd_valid),
        .fwd_desc_o     (fwd_desc),
        .fwd_src_port_o (fwd_src_port),
        .fwd_mask_o     (fwd_mask),
        .fwd_kind_o     (fwd_kind)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic compare_desc(input string name, input mac_pair_t got, input mac_pair_t exp);
        if (got !== exp) report_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic compare_mask(input string name, input logic [NUM_PORTS-1:0] got,
                                input logic [NUM_PORTS-1:0] exp);
        if (got !== exp) report_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic compare_kind(input string name, input fwd_kind_t got, input fwd_kind_t exp);
        if (got !== exp) report_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    function automatic mac_addr_t pool_mac(input int k);
        if (k >= POOL_SIZE) return BROADCAST_MAC;
        return 48'h0200_5E00_1000 + 48'(k) * 48'h11;
    endfunction

    function automatic mac_pair_t random_desc();
        mac_pair_t d;
        d.src_mac = pool_mac(int'($urandom % POOL_SIZE));
        d.dst_mac = pool_mac(int'($urandom % (POOL_SIZE + 1))); // Broadcast included
        return d;
    endfunction

    // First unused slot, else the smallest count with the lowest index
    function automatic int choose_victim();
        int best;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!ref_used[i]) return i;
        end
        best = 0;
        for (int i = 1; i < NUM_ENTRIES; i++) begin
            if (ref_hits[i] < ref_hits[best]) best = i;
        end
        return best;
    endfunction

    // Lookup on the old table, then learn, as one edge of the table
    task automatic table_step(input mac_pair_t d, input int port, output bit hit,
                              output int hit_port);
        int victim;
        int match_idx;
        bit exists;
        bit write;
        bit all_used;

        hit       = 1'b0;
        hit_port  = 0;
        match_idx = -1;
        exists    = 1'b0;
        all_used  = 1'b1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (ref_used[i] && ref_addr[i] == d.dst_mac) begin
                hit       = 1'b1;
                hit_port  = ref_port[i];
                match_idx = i;
            end
            if (ref_used[i] && ref_addr[i] == d.src_mac && ref_port[i] == port) exists = 1'b1;
            if (!ref_used[i]) all_used = 1'b0;
        end
        victim = choose_victim();
        write  = !exists;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!(write && i == victim)) begin
                if (i == match_idx) begin
                    if (ref_hits[i] < MAX_HIT - 1) ref_hits[i]++;
                end else if (ref_hits[i] > 0) begin
                    ref_hits[i]--;
                end
            end
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (ref_used[i] && ref_addr[i] == d.src_mac && ref_port[i] != port) begin
                ref_used[i] = 1'b0;
                moves++;
            end
        end
        if (write) begin
            if (all_used) evictions++;
            ref_used[victim] = 1'b1;
            ref_addr[victim] = d.src_mac;
            ref_port[victim] = port;
            ref_hits[victim] = 1;
        end
    endtask

    task automatic check_output();
        int                   port;
        mac_pair_t            exp_desc;
        bit                   hit;
        int                   hit_port;
        logic [NUM_PORTS-1:0] src_bit;
        logic [NUM_PORTS-1:0] exp_mask;
        fwd_kind_t            exp_kind;

        port = int'(fwd_src_port);
        if (model_q[port].size() == 0) begin
            report_failure($sformatf("Descriptor left port %0d but none was queued there", port));
        end else begin
            exp_desc = model_q[port].pop_front();
            table_step(exp_desc, port, hit, hit_port);
            src_bit       = '0;
            src_bit[port] = 1'b1;
            exp_mask      = '0;
            if (exp_desc.dst_mac == BROADCAST_MAC) begin
                exp_kind = FWD_BROADCAST;
                exp_mask = ~src_bit;
            end else if (hit && hit_port != port) begin
                exp_kind           = FWD_UNICAST;
                exp_mask[hit_port] = 1'b1;
            end else if (hit) begin
                exp_kind = FWD_FILTER;
            end else begin
                exp_kind = FWD_FLOOD;
                exp_mask = ~src_bit;
            end
            forwarded++;
            kind_seen[int'(exp_kind)]++;
            compare_desc("fwd_desc_o", fwd_desc, exp_desc);
            compare_mask("fwd_mask_o", fwd_mask, exp_mask);
            compare_kind("fwd_kind_o", fwd_kind, exp_kind);
        end
    endtask

    // Sample on the edge, before this edge's updates land
    always @(posedge clk) begin
        if (rst_n) begin
            if (fwd_valid) check_output();
            // Queue holds the FIFO plus at most two descriptors past it
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (in_full[p] && model_q[p].size() < FIFO_DEPTH) begin
                    report_failure($sformatf("Port %0d reported full with only %0d queued",
                                             p, model_q[p].size()));
                end else if (!in_full[p] && model_q[p].size() >= FIFO_DEPTH + 2) begin
                    report_failure($sformatf("Port %0d not reported full with %0d queued",
                                             p, model_q[p].size()));
                end
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (in_valid[p] && in_full[p]) begin
                    dropped++;
                end else if (in_valid[p]) begin
                    model_q[p].push_back(in_desc[p]);
                    accepted++;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        report_failure("Watchdog expired before the test sequence finished");
    end

    initial begin
        int unsigned load;
        int          lat;
        int          drain;
        string       gap;

        void'($urandom(76));
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        #1;
        compare_mask("in_full_o", in_full, '0);
        if (fwd_valid) report_failure("Output valid was high right after reset");

        // Single descriptor into an idle engine
        @(posedge clk);
        in_valid[0] <= 1'b1;
        in_desc[0]  <= random_desc();
        @(posedge clk);
        in_valid[0] <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!fwd_valid && lat < LAT_LIMIT);
        if (!fwd_valid) begin
            report_failure("Isolated descriptor never reached the output");
        end else if (lat != 3) begin
            report_failure($sformatf("Isolated descriptor took %0d cycles instead of 3", lat));
        end

        for (int c = 0; c < STIM_CYCLES; c++) begin
            @(posedge clk);
            if (c % 64 == 0) load = 1 + $urandom % 5; // Light to overloaded bursts
            for (int p = 0; p < NUM_PORTS; p++) begin
                in_valid[p] <= (($urandom % 8) < load);
                in_desc[p]  <= random_desc();
            end
        end
        @(posedge clk);
        in_valid <= '0;

        drain = 0;
        while (forwarded != accepted && drain < DRAIN_CYCLES) begin
            @(posedge clk);
            #1;
            drain++;
        end
        repeat (4) @(posedge clk);
        #1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (model_q[p].size() != 0) begin
                report_failure($sformatf("Port %0d still holds %0d descriptors that never came out",
                                         p, model_q[p].size()));
            end
        end

        gap = "";
        if (dropped == 0) gap = {gap, " overflow"};
        if (evictions == 0) gap = {gap, " eviction"};
        if (moves == 0) gap = {gap, " station-move"};
        for (int k = 0; k < 4; k++) begin
            if (kind_seen[k] == 0) gap = {gap, $sformatf(" kind-%0d", k)};
        end
        if (gap != "") begin
            report_failure({"Traffic never exercised:", gap});
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: list.f
switch_pkg.sv
desc_fifo.sv
rr_arbiter.sv
address_table.sv
forward_decision.sv
forwarding_engine.sv
tb_forwarding_engine.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the forwarding engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --timescale 1ns/1ps \
    --top-module tb_forwarding_engine -f list.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1
